/* kbc_cfg.svh */
// ==========================================================
// Build-time defaults for the keyboard controller
// FIFO depth must be at least 1; reset values follow 8042 usage
// ==========================================================
`ifndef KBC_CFG_SVH
`define KBC_CFG_SVH

// Receive FIFO entries between the keyboard model and the output buffer
`define KBC_FIFO_DEPTH 16

// Configuration byte after reset
// IRQ enable, SYS flag and translation set; keyboard enabled
`define KBC_CONFIG_RESET 8'h47

// Output port after reset
// Bit 0 is the CPU reset line (inactive high), bit 1 is A20
`define KBC_OUTPORT_RESET 8'h03

`endif

/* kbc_pkg.sv */
// ==========================================================
// Shared types and encodings of the 8042-style controller
// Offsets are relative to the controller's I/O window
// ==========================================================
package kbc_pkg;

    typedef logic [7:0] kbc_byte_t;  // Any byte on host or keyboard paths
    typedef logic [2:0] kbc_addr_t;  // I/O offset inside the window

    // Port offsets (60h and 64h on a PC)
    localparam kbc_addr_t PORT_DATA = 3'd0;
    localparam kbc_addr_t PORT_CTRL = 3'd4;

    // Controller commands written to PORT_CTRL
    localparam kbc_byte_t CMD_READ_CONFIG  = 8'h20;
    localparam kbc_byte_t CMD_WRITE_CONFIG = 8'h60;
    localparam kbc_byte_t CMD_SELF_TEST    = 8'hAA;
    localparam kbc_byte_t CMD_TEST_KB      = 8'hAB;
    localparam kbc_byte_t CMD_DISABLE_KB   = 8'hAD;
    localparam kbc_byte_t CMD_ENABLE_KB    = 8'hAE;
    localparam kbc_byte_t CMD_READ_OUTPUT  = 8'hD0;
    localparam kbc_byte_t CMD_WRITE_OUTPUT = 8'hD1;

    // Fixed command responses
    localparam kbc_byte_t RESP_SELF_TEST_OK = 8'h55;
    localparam kbc_byte_t RESP_KB_TEST_OK   = 8'h00;

    // Status register bits
    localparam int unsigned ST_OBF = 0;  // Output buffer full
    localparam int unsigned ST_IBF = 1;  // Input buffer full
    localparam int unsigned ST_SYS = 2;  // Copy of the config SYS flag
    localparam int unsigned ST_CMD = 3;  // Parameter byte awaited

    // Configuration byte bits
    localparam int unsigned CFG_IRQ_EN = 0;
    localparam int unsigned CFG_SYS    = 2;
    localparam int unsigned CFG_KB_DIS = 4;

    // Which parameter the next data-port write carries
    typedef enum logic [1:0] {
        PH_IDLE,
        PH_WAIT_CONFIG,
        PH_WAIT_OUTPUT
    } kbc_phase_t;

endpackage

/* kbc_rx_fifo.sv */
// ==========================================================
// Receive FIFO for keyboard bytes, any DEPTH of 1 or more
// A push into a full FIFO is lost unless a pop happens too
// pop_data shows the head entry; it is stale while empty
// ==========================================================
`timescale 1ns/1ps

module kbc_rx_fifo #(
    parameter int unsigned DEPTH = 4
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               push,
    input  kbc_pkg::kbc_byte_t push_data,
    input  logic               pop,
    output kbc_pkg::kbc_byte_t pop_data,
    output logic               empty
);
    import kbc_pkg::*;

    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    kbc_byte_t        mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             do_push;
    logic             do_pop;

    assign empty    = (count == '0);
    assign full     = (count == CNT_W'(DEPTH));
    assign do_pop   = pop && !empty;
    assign do_push  = push && (!full || do_pop);  // Slot freed by the pop is reused
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end

            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Idle, or push and pop together
            endcase
        end
    end

endmodule

/* kbc_host_engine.sv */
// ==========================================================
// Host side of the controller: port decode, commands, status
// Host accesses are single-cycle strobes with no wait states
// A response overwrites an unread keyboard byte in the buffer
// ==========================================================
`timescale 1ns/1ps
`include "kbc_cfg.svh"

module kbc_host_engine (
    input  logic               clk,
    input  logic               rst_n,
    input  kbc_pkg::kbc_addr_t io_address,
    input  logic               io_read,
    input  logic               io_write,
    input  kbc_pkg::kbc_byte_t io_writedata,
    output kbc_pkg::kbc_byte_t io_readdata,
    output logic               irq_keyb,
    input  kbc_pkg::kbc_byte_t fifo_data,
    input  logic               fifo_empty,
    output logic               fifo_pop,
    output logic               kb_data_rd,
    output kbc_pkg::kbc_byte_t kb_cmd_out,
    output logic               kb_cmd_valid,
    output kbc_pkg::kbc_byte_t status_reg
);
    import kbc_pkg::*;

    kbc_byte_t  config_byte;
    kbc_byte_t  output_port;
    kbc_byte_t  output_buffer;
    logic       output_buffer_full;
    kbc_phase_t phase;

    logic       cmd_write;   // Controller command this cycle
    logic       data_write;  // Data-port write this cycle
    logic       data_read;   // Host consumes the output buffer
    logic       resp_valid;  // Command loads a response
    kbc_byte_t  resp_data;

    assign cmd_write  = io_write && (io_address == PORT_CTRL);
    assign data_write = io_write && (io_address == PORT_DATA);
    assign data_read  = io_read && (io_address == PORT_DATA);

    // Responses for the commands that return a byte
    always_comb begin
        resp_valid = 1'b0;
        resp_data  = RESP_KB_TEST_OK;
        if (cmd_write) begin
            case (io_writedata)
                CMD_READ_CONFIG: begin
                    resp_valid = 1'b1;
                    resp_data  = config_byte;
                end
                CMD_TEST_KB: begin
                    resp_valid = 1'b1;
                    resp_data  = RESP_KB_TEST_OK;
                end
                CMD_SELF_TEST: begin
                    resp_valid = 1'b1;
                    resp_data  = RESP_SELF_TEST_OK;
                end
                CMD_READ_OUTPUT: begin
                    resp_valid = 1'b1;
                    resp_data  = output_port;
                end
                default: begin
                    resp_valid = 1'b0;
                end
            endcase
        end
    end

    // Keyboard byte moves only into an empty buffer, and never past a response
    assign fifo_pop = !output_buffer_full && !fifo_empty &&
                      !config_byte[CFG_KB_DIS] && !resp_valid;

    always_comb begin
        status_reg         = '0;
        status_reg[ST_OBF] = output_buffer_full;
        status_reg[ST_IBF] = 1'b0;  // Writes are taken in the same cycle
        status_reg[ST_SYS] = config_byte[CFG_SYS];
        status_reg[ST_CMD] = (phase != PH_IDLE);
    end

    always_comb begin
        case (io_address)
            PORT_DATA: io_readdata = output_buffer;
            PORT_CTRL: io_readdata = status_reg;
            default:   io_readdata = 8'hFF;  // Unmapped offsets float high
        endcase
    end

    // Buffer contents and keyboard command byte
    always_ff @(posedge clk) begin
        if (resp_valid) begin
            output_buffer <= resp_data;
        end else if (fifo_pop) begin
            output_buffer <= fifo_data;
        end
        if (data_write && phase == PH_IDLE) begin
            kb_cmd_out <= io_writedata;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            config_byte        <= `KBC_CONFIG_RESET;
            output_port        <= `KBC_OUTPORT_RESET;
            output_buffer_full <= 1'b0;
            phase              <= PH_IDLE;
            irq_keyb           <= 1'b0;
            kb_data_rd         <= 1'b0;
            kb_cmd_valid       <= 1'b0;
        end else begin
            kb_data_rd   <= fifo_pop;  // Acknowledge to the keyboard model
            kb_cmd_valid <= data_write && (phase == PH_IDLE);

            // Later assignments win: a load on the same edge beats the read
            if (data_read) begin
                output_buffer_full <= 1'b0;
                irq_keyb           <= 1'b0;
            end
            if (fifo_pop) begin
                output_buffer_full <= 1'b1;
                irq_keyb           <= config_byte[CFG_IRQ_EN];
            end
            if (resp_valid) begin
                output_buffer_full <= 1'b1;
                irq_keyb           <= 1'b0;  // Responses are polled
            end

            if (cmd_write) begin
                phase <= PH_IDLE;  // A new command drops a pending parameter
                case (io_writedata)
                    CMD_WRITE_CONFIG: phase <= PH_WAIT_CONFIG;
                    CMD_WRITE_OUTPUT: phase <= PH_WAIT_OUTPUT;
                    CMD_DISABLE_KB:   config_byte[CFG_KB_DIS] <= 1'b1;
                    CMD_ENABLE_KB:    config_byte[CFG_KB_DIS] <= 1'b0;
                    default: begin
                        // Reads and tests only load a response
                    end
                endcase
            end else if (data_write) begin
                case (phase)
                    PH_WAIT_CONFIG: config_byte <= io_writedata;
                    PH_WAIT_OUTPUT: output_port <= io_writedata;
                    default: begin
                        // Byte went to the keyboard instead
                    end
                endcase
                phase <= PH_IDLE;
            end
        end
    end

endmodule

/* kbc_top.sv */
// ==========================================================
// Keyboard controller top: receive FIFO plus host engine
// Keyboard side uses plain strobes; no PS/2 line timing
// ==========================================================
`timescale 1ns/1ps
`include "kbc_cfg.svh"

module kbc_top (
    input  logic               clk,
    input  logic               rst_n,

    // Host I/O window
    input  kbc_pkg::kbc_addr_t io_address,
    input  logic               io_read,
    input  logic               io_write,
    input  kbc_pkg::kbc_byte_t io_writedata,
    output kbc_pkg::kbc_byte_t io_readdata,
    output logic               irq_keyb,

    // Keyboard model
    input  kbc_pkg::kbc_byte_t kb_data_in,
    input  logic               kb_data_valid,
    output logic               kb_data_rd,
    output kbc_pkg::kbc_byte_t kb_cmd_out,
    output logic               kb_cmd_valid,

    output kbc_pkg::kbc_byte_t status_reg
);
    import kbc_pkg::*;

    kbc_byte_t fifo_data;
    logic      fifo_empty;
    logic      fifo_pop;

    kbc_rx_fifo #(
        .DEPTH (`KBC_FIFO_DEPTH)
    ) u_rx_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (kb_data_valid),
        .push_data (kb_data_in),
        .pop       (fifo_pop),
        .pop_data  (fifo_data),
        .empty     (fifo_empty)
    );

    kbc_host_engine u_engine (
        .clk          (clk),
        .rst_n        (rst_n),
        .io_address   (io_address),
        .io_read      (io_read),
        .io_write     (io_write),
        .io_writedata (io_writedata),
        .io_readdata  (io_readdata),
        .irq_keyb     (irq_keyb),
        .fifo_data    (fifo_data),
        .fifo_empty   (fifo_empty),
        .fifo_pop     (fifo_pop),
        .kb_data_rd   (kb_data_rd),
        .kb_cmd_out   (kb_cmd_out),
        .kb_cmd_valid (kb_cmd_valid),
        .status_reg   (status_reg)
    );

endmodule

/* kbc_assert.sv */
// ==========================================================
// Concurrent checks on the host engine, bound by module name
// All properties are off while rst_n is low
// ==========================================================
`timescale 1ns/1ps

module kbc_assert (
    input logic                clk,
    input logic                rst_n,
    input kbc_pkg::kbc_addr_t  io_address,
    input logic                io_write,
    input logic                irq_keyb,
    input logic                kb_cmd_valid,
    input logic                kb_data_rd,
    input logic                output_buffer_full,
    input kbc_pkg::kbc_phase_t phase
);
    import kbc_pkg::*;

    logic cmd_write;

    assign cmd_write = io_write && (io_address == PORT_CTRL);

    // Keyboard-side strobes are single pulses
    a_cmd_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        kb_cmd_valid |=> !kb_cmd_valid)
        else $error("kb_cmd_valid high for two cycles in a row");

    a_rd_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        kb_data_rd |=> !kb_data_rd)
        else $error("kb_data_rd high for two cycles in a row");

    a_irq_obf: assert property (@(posedge clk) disable iff (!rst_n)
        irq_keyb |-> output_buffer_full)
        else $error("irq_keyb set while the output buffer is empty");

    // Parameter phase is entered from a controller command only
    a_phase_entry: assert property (@(posedge clk) disable iff (!rst_n)
        (phase == PH_IDLE && !cmd_write) |=> (phase == PH_IDLE))
        else $error("Phase left PH_IDLE without a command write");

endmodule

bind kbc_host_engine kbc_assert u_assert (
    .clk                (clk),
    .rst_n              (rst_n),
    .io_address         (io_address),
    .io_write           (io_write),
    .irq_keyb           (irq_keyb),
    .kb_cmd_valid       (kb_cmd_valid),
    .kb_data_rd         (kb_data_rd),
    .output_buffer_full (output_buffer_full),
    .phase              (phase)
);

/* kbc_tb.sv */
// ============================================================
// Table-driven testbench for the keyboard controller top
// Each step spans two clocks with strobes first and then idle
// Reads sample before the step's acting edge and flags after it
// ============================================================
`timescale 1ns/1ps
`include "kbc_cfg.svh"

module kbc_tb;
    import kbc_pkg::*;

    typedef enum logic [2:0] {
        OP_WR_CTRL,
        OP_WR_DATA,
        OP_RD_DATA,
        OP_RD_STAT,
        OP_PUSH,
        OP_IDLE
    } op_t;

    typedef struct packed {
        op_t        op;
        logic [2:0] grp;
        kbc_byte_t  data;
        kbc_byte_t  exp;    // Read value on read steps
        logic       irq;    // irq_keyb after the step
        logic       kbcmd;  // kb_cmd_valid after the step
        logic [7:0] rdcnt;  // kb_data_rd pulses due after a keyboard read
    } step_t;

    logic      clk = 1'b0;
    logic      rst_n;
    kbc_addr_t io_address;
    logic      io_read;
    logic      io_write;
    kbc_byte_t io_writedata;
    kbc_byte_t io_readdata;
    logic      irq_keyb;
    kbc_byte_t kb_data_in;
    logic      kb_data_valid;
    logic      kb_data_rd;
    kbc_byte_t kb_cmd_out;
    logic      kb_cmd_valid;
    kbc_byte_t status_reg;

    step_t       steps[$];
    kbc_byte_t   expq[$];  // Keyboard bytes in expected read order
    logic [2:0]  cur_grp;
    logic [31:0] rng_state = 32'hbc98_0320;
    int          step_idx;
    int          cycles = 0;
    int          cycle_limit = 1000;
    int          total_checks = 0;
    int          total_errors = 0;
    int          grp_checks = 0;
    int          grp_errors = 0;
    int          key_reads = 0;  // Keyboard bytes read back in the table
    int          rd_pulses = 0;  // Delivery strobes seen since reset

    kbc_top dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .io_address    (io_address),
        .io_read       (io_read),
        .io_write      (io_write),
        .io_writedata  (io_writedata),
        .io_readdata   (io_readdata),
        .irq_keyb      (irq_keyb),
        .kb_data_in    (kb_data_in),
        .kb_data_valid (kb_data_valid),
        .kb_data_rd    (kb_data_rd),
        .kb_cmd_out    (kb_cmd_out),
        .kb_cmd_valid  (kb_cmd_valid),
        .status_reg    (status_reg)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: no result after %0d cycles", cycle_limit);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // One count per cycle that kb_data_rd is high
    always @(posedge clk) begin
        if (kb_data_rd === 1'b1) begin
            rd_pulses <= rd_pulses + 1;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic kbc_byte_t next_key_byte();
        rng_state = xorshift32(rng_state);
        return rng_state[7:0];
    endfunction

    // Status byte the host should see for a given controller state
    function automatic kbc_byte_t status_of(input logic obf, input logic cmd,
                                            input kbc_byte_t cfg);
        kbc_byte_t st;
        st         = '0;
        st[ST_OBF] = obf;
        st[ST_SYS] = cfg[CFG_SYS];
        st[ST_CMD] = cmd;
        return st;
    endfunction

    function automatic string group_name(input logic [2:0] g);
        case (g)
            3'd0:    return "reset and self-test";
            3'd1:    return "configuration write";
            3'd2:    return "keyboard burst";
            3'd3:    return "keyboard disable";
            3'd4:    return "keyboard command and output port";
            default: return "FIFO overflow";
        endcase
    endfunction

    task automatic add_step(input op_t op, input kbc_byte_t data, input kbc_byte_t exp,
                            input logic irq, input logic kbcmd);
        step_t s;
        s.op    = op;
        s.grp   = cur_grp;
        s.data  = data;
        s.exp   = exp;
        s.irq   = irq;
        s.kbcmd = kbcmd;
        s.rdcnt = 8'h00;
        steps.push_back(s);
    endtask

    // Each delivered keyboard byte carries one kb_data_rd pulse
    task automatic add_key_read();
        step_t s;
        key_reads++;
        s.op    = OP_RD_DATA;
        s.grp   = cur_grp;
        s.data  = 8'h00;
        s.exp   = expq.pop_front();
        s.irq   = 1'b0;
        s.kbcmd = 1'b0;
        s.rdcnt = 8'(key_reads);
        steps.push_back(s);
    endtask

    task automatic check_value(input string name, input kbc_byte_t actual,
                               input kbc_byte_t expected);
        total_checks++;
        grp_checks++;
        if (actual !== expected) begin
            total_errors++;
            grp_errors++;
            $display("Mismatch %s at step %0d: got %h, expected %h",
                     name, step_idx, actual, expected);
        end
    endtask

    task automatic report_group(input logic [2:0] g);
        $display("Group %0d (%s): %0d checks, %0d errors",
                 g + 1, group_name(g), grp_checks, grp_errors);
        grp_checks = 0;
        grp_errors = 0;
    endtask

    task automatic build_table();
        int        k;
        kbc_byte_t b;
        cur_grp = 3'd0;
        add_step(OP_RD_STAT, 8'h00, status_of(1'b0, 1'b0, `KBC_CONFIG_RESET), 1'b0, 1'b0);
        add_step(OP_WR_CTRL, CMD_SELF_TEST, 8'h00, 1'b0, 1'b0);
        add_step(OP_RD_STAT, 8'h00, status_of(1'b1, 1'b0, `KBC_CONFIG_RESET), 1'b0, 1'b0);
        add_step(OP_RD_DATA, 8'h00, RESP_SELF_TEST_OK, 1'b0, 1'b0);
        add_step(OP_RD_STAT, 8'h00, status_of(1'b0, 1'b0, `KBC_CONFIG_RESET), 1'b0, 1'b0);
        add_step(OP_WR_CTRL, CMD_TEST_KB, 8'h00, 1'b0, 1'b0);
        add_step(OP_RD_DATA, 8'h00, RESP_KB_TEST_OK, 1'b0, 1'b0);
        add_step(OP_RD_STAT, 8'h00, status_of(1'b0, 1'b0, `KBC_CONFIG_RESET), 1'b0, 1'b0);

        // SYS cleared, read back, then restored with IRQ enabled
        cur_grp = 3'd1;
        add_step(OP_WR_CTRL, CMD_WRITE_CONFIG, 8'h00, 1'b0, 1'b0);
        add_step(OP_RD_STAT, 8'h00, status_of(1'b0, 1'b1, `KBC_CONFIG_RESET), 1'b0, 1'b0);
        add_step(OP_WR_DATA, 8'h41, 8'h00, 1'b0, 1'b0);
        add_step(OP_RD_STAT, 8'h00, status_of(1'b0, 1'b0, 8'h41), 1'b0, 1'b0);
        add_step(OP_WR_CTRL, CMD_READ_CONFIG, 8'h00, 1'b0, 1'b0);
        add_step(OP_RD_DATA, 8'h00, 8'h41, 1'b0, 1'b0);
        add_step(OP_WR_CTRL, CMD_WRITE_CONFIG, 8'h00, 1'b0, 1'b0);
        add_step(OP_WR_DATA, 8'h45, 8'h00, 1'b0, 1'b0);
        add_step(OP_RD_STAT, 8'h00, status_of(1'b0, 1'b0, 8'h45), 1'b0, 1'b0);

        cur_grp = 3'd2;
        for (k = 0; k < 4; k++) begin
            b = next_key_byte();
            expq.push_back(b);
            add_step(OP_PUSH, b, 8'h00, k > 0, 1'b0);  // First byte loads one step later
        end
        add_step(OP_IDLE, 8'h00, 8'h00, 1'b1, 1'b0);
        for (k = 0; k < 4; k++) begin
            add_step(OP_IDLE, 8'h00, 8'h00, 1'b1, 1'b0);  // Waiting byte holds irq
            add_key_read();
        end
        add_step(OP_IDLE, 8'h00, 8'h00, 1'b0, 1'b0);
        add_step(OP_RD_STAT, 8'h00, status_of(1'b0, 1'b0, 8'h45), 1'b0, 1'b0);
        // Interrupt enable cleared
        add_step(OP_WR_CTRL, CMD_WRITE_CONFIG, 8'h00, 1'b0, 1'b0);
        add_step(OP_WR_DATA, 8'h44, 8'h00, 1'b0, 1'b0);
        for (k = 0; k < 2; k++) begin
            b = next_key_byte();
            expq.push_back(b);
            add_step(OP_PUSH, b, 8'h00, 1'b0, 1'b0);
        end
        add_step(OP_IDLE, 8'h00, 8'h00, 1'b0, 1'b0);
        add_step(OP_IDLE, 8'h00, 8'h00, 1'b0, 1'b0);
        for (k = 0; k < 2; k++) begin
            add_key_read();
        end
        add_step(OP_RD_STAT, 8'h00, status_of(1'b0, 1'b0, 8'h44), 1'b0, 1'b0);

        cur_grp = 3'd3;
        add_step(OP_WR_CTRL, CMD_DISABLE_KB, 8'h00, 1'b0, 1'b0);
        for (k = 0; k < 2; k++) begin
            b = next_key_byte();
            expq.push_back(b);
            add_step(OP_PUSH, b, 8'h00, 1'b0, 1'b0);
        end
        add_step(OP_IDLE, 8'h00, 8'h00, 1'b0, 1'b0);
        add_step(OP_IDLE, 8'h00, 8'h00, 1'b0, 1'b0);
        add_step(OP_RD_STAT, 8'h00, status_of(1'b0, 1'b0, 8'h54), 1'b0, 1'b0);
        add_step(OP_WR_CTRL, CMD_ENABLE_KB, 8'h00, 1'b0, 1'b0);
        add_step(OP_IDLE, 8'h00, 8'h00, 1'b0, 1'b0);
        add_step(OP_IDLE, 8'h00, 8'h00, 1'b0, 1'b0);
        add_step(OP_RD_STAT, 8'h00, status_of(1'b1, 1'b0, 8'h44), 1'b0, 1'b0);
        for (k = 0; k < 2; k++) begin
            add_key_read();
        end
        add_step(OP_RD_STAT, 8'h00, status_of(1'b0, 1'b0, 8'h44), 1'b0, 1'b0);

        cur_grp = 3'd4;
        add_step(OP_WR_DATA, 8'hED, 8'h00, 1'b0, 1'b1);
        add_step(OP_IDLE, 8'h00, 8'h00, 1'b0, 1'b0);
        add_step(OP_WR_CTRL, CMD_READ_OUTPUT, 8'h00, 1'b0, 1'b0);
        add_step(OP_RD_DATA, 8'h00, `KBC_OUTPORT_RESET, 1'b0, 1'b0);
        add_step(OP_WR_CTRL, CMD_WRITE_OUTPUT, 8'h00, 1'b0, 1'b0);
        add_step(OP_RD_STAT, 8'h00, status_of(1'b0, 1'b1, 8'h44), 1'b0, 1'b0);
        add_step(OP_WR_DATA, 8'hDF, 8'h00, 1'b0, 1'b0);  // Parameter rather than a keyboard command
        add_step(OP_WR_CTRL, CMD_READ_OUTPUT, 8'h00, 1'b0, 1'b0);
        add_step(OP_RD_DATA, 8'h00, 8'hDF, 1'b0, 1'b0);
        add_step(OP_RD_STAT, 8'h00, status_of(1'b0, 1'b0, 8'h44), 1'b0, 1'b0);

        cur_grp = 3'd5;
        add_step(OP_WR_CTRL, CMD_DISABLE_KB, 8'h00, 1'b0, 1'b0);
        for (k = 0; k <= `KBC_FIFO_DEPTH; k++) begin
            b = next_key_byte();
            if (expq.size() < `KBC_FIFO_DEPTH)
                expq.push_back(b);  // A full FIFO drops the byte
            add_step(OP_PUSH, b, 8'h00, 1'b0, 1'b0);
        end
        add_step(OP_IDLE, 8'h00, 8'h00, 1'b0, 1'b0);
        add_step(OP_IDLE, 8'h00, 8'h00, 1'b0, 1'b0);
        add_step(OP_RD_STAT, 8'h00, status_of(1'b0, 1'b0, 8'h54), 1'b0, 1'b0);
        add_step(OP_WR_CTRL, CMD_ENABLE_KB, 8'h00, 1'b0, 1'b0);
        add_step(OP_IDLE, 8'h00, 8'h00, 1'b0, 1'b0);
        add_step(OP_IDLE, 8'h00, 8'h00, 1'b0, 1'b0);
        for (k = 0; k < `KBC_FIFO_DEPTH; k++) begin
            add_key_read();
        end
        add_step(OP_IDLE, 8'h00, 8'h00, 1'b0, 1'b0);
        add_step(OP_RD_STAT, 8'h00, status_of(1'b0, 1'b0, 8'h44), 1'b0, 1'b0);
    endtask

    task automatic drive_step(input step_t s);
        io_read       <= (s.op == OP_RD_DATA) || (s.op == OP_RD_STAT);
        io_write      <= (s.op == OP_WR_CTRL) || (s.op == OP_WR_DATA);
        io_address    <= (s.op == OP_WR_CTRL || s.op == OP_RD_STAT) ? PORT_CTRL : PORT_DATA;
        io_writedata  <= s.data;
        kb_data_in    <= s.data;
        kb_data_valid <= (s.op == OP_PUSH);
    endtask

    task automatic release_strobes();
        io_read       <= 1'b0;
        io_write      <= 1'b0;
        kb_data_valid <= 1'b0;
    endtask

    initial begin
        step_t s;
        rst_n         = 1'b0;
        io_address    = PORT_DATA;
        io_read       = 1'b0;
        io_write      = 1'b0;
        io_writedata  = 8'h00;
        kb_data_in    = 8'h00;
        kb_data_valid = 1'b0;
        build_table();
        cycle_limit = 4 * steps.size() + 50;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        for (step_idx = 0; step_idx < steps.size(); step_idx++) begin
            s = steps[step_idx];
            if (step_idx > 0 && s.grp != steps[step_idx - 1].grp)
                report_group(steps[step_idx - 1].grp);
            @(posedge clk);
            drive_step(s);
            @(negedge clk);
            if (s.op == OP_RD_DATA)
                check_value("io_readdata", io_readdata, s.exp);
            if (s.op == OP_RD_STAT) begin
                check_value("io_readdata", io_readdata, s.exp);
                check_value("status_reg", status_reg, s.exp);
            end
            @(posedge clk);
            release_strobes();
            @(negedge clk);
            check_value("irq_keyb", kbc_byte_t'(irq_keyb), kbc_byte_t'(s.irq));
            check_value("kb_cmd_valid", kbc_byte_t'(kb_cmd_valid), kbc_byte_t'(s.kbcmd));
            if (s.kbcmd)
                check_value("kb_cmd_out", kb_cmd_out, s.data);
            if (s.rdcnt != 8'h00)
                check_value("kb_data_rd count", kbc_byte_t'(rd_pulses), s.rdcnt);
        end
        report_group(steps[steps.size() - 1].grp);

        $display("Done: %0d checks, %0d errors", total_checks, total_errors);
        if (total_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* kbc_top.f */
+incdir+.
kbc_pkg.sv
kbc_rx_fifo.sv
kbc_host_engine.sv
kbc_top.sv
kbc_assert.sv
kbc_tb.sv

/* Bender.yml */
package:
  name: kbc

sources:
  - include_dirs:
      - .
    files:
      - kbc_pkg.sv
      - kbc_rx_fifo.sv
      - kbc_host_engine.sv
      - kbc_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - kbc_assert.sv
      - kbc_tb.sv
